// File: filelist.f
+incdir+.
rv64_pkg.sv
inst_queue.sv
id_stage.sv
regfile.sv
alu.sv
exe_stage.sv
rv64_slice_top.sv
rv64_chk.sv
rv64_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module rv64_tb -o rv64_sim
if ! ./obj_dir/rv64_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation aborted"
	exit 1
fi
cat sim.log
if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi

// File: rv64_tb.sv
// testbench for the RV64I slice, reference model with credit-driven stimulus
`include "rv64_macros.svh"

module rv64_tb;
	typedef struct {
		logic [63:0] pc;
		logic [63:0] data;
		logic [63:0] target;
		logic [4:0]  rd;
		logic        rd_wena;
		logic        br_taken;
		logic        rena;
		logic        wena;
		logic [7:0]  be;
		logic        illegal;
	} res_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [31:0] in_inst;
	logic [63:0] in_pc;
	logic        in_credit;
	logic        res_credit;
	logic        res_valid;
	logic [63:0] res_pc;
	logic [63:0] res_data;
	logic [4:0]  res_rd;
	logic        res_rd_wena;
	logic        res_br_taken;
	logic [63:0] res_target;
	logic        res_mem_rena;
	logic        res_mem_wena;
	logic [7:0]  res_byte_enable;
	logic        res_illegal;

	logic [31:0] lfsr;
	logic [63:0] shadow [32];
	logic [31:0] prog [$];
	res_t        expq [$];
	res_t        head;
	int          credits;
	int          pend;
	int          sent;
	int          received;
	int          mismatches;
	int          failures;

	rv64_slice_top u_dut (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_inst(in_inst), .in_pc(in_pc),
		.in_credit(in_credit), .res_credit(res_credit), .res_valid(res_valid),
		.res_pc(res_pc), .res_data(res_data), .res_rd(res_rd), .res_rd_wena(res_rd_wena),
		.res_br_taken(res_br_taken), .res_target(res_target),
		.res_mem_rena(res_mem_rena), .res_mem_wena(res_mem_wena),
		.res_byte_enable(res_byte_enable), .res_illegal(res_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois step, returns the bit shifted out
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// architectural result of one instruction, updates the shadow registers
	function automatic res_t model(input logic [31:0] inst, input logic [63:0] pc);
		res_t        r;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic        word;
		logic [63:0] a;
		logic [63:0] op2;
		logic [63:0] imm_i;
		logic [63:0] imm_s;
		logic [63:0] imm_b;
		logic [63:0] imm_u;
		logic [63:0] imm_j;
		logic [31:0] w;
		logic [5:0]  sh;
		opc = inst[6:0];
		f3 = inst[14:12];
		a = shadow[inst[19:15]];
		imm_i = {{52{inst[31]}}, inst[31:20]};
		imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
		imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		r = '{default: '0};
		r.pc = pc;
		r.rd = inst[11:7];
		r.be = (f3[1:0] == 2'd0) ? 8'h01 : (f3[1:0] == 2'd1) ? 8'h03 :
			(f3[1:0] == 2'd2) ? 8'h0f : 8'hff;
		case (opc)
			7'h13, 7'h1b, 7'h33, 7'h3b: begin
				word = opc[3];
				op2 = opc[5] ? shadow[inst[24:20]] : imm_i;
				sh = word ? {1'b0, op2[4:0]} : op2[5:0];
				r.rd_wena = 1'b1;
				r.be = '0;
				case (f3)
					3'd0: r.data = (opc[5] && inst[30]) ? a - op2 : a + op2;
					3'd1: r.data = word ? {32'b0, a[31:0] << sh} : a << sh;
					3'd2: r.data = {63'b0, $signed(a) < $signed(op2)};
					3'd3: r.data = {63'b0, a < op2};
					3'd4: r.data = a ^ op2;
					3'd5: begin
						if (word && inst[30]) begin
							w = $signed(a[31:0]) >>> sh;
							r.data = {32'b0, w};
						end else if (word)
							r.data = {32'b0, a[31:0] >> sh};
						else if (inst[30])
							r.data = $signed(a) >>> sh;
						else
							r.data = a >> sh;
					end
					3'd6: r.data = a | op2;
					default: r.data = a & op2;
				endcase
				if (word)
					r.data = {{32{r.data[31]}}, r.data[31:0]};
			end
			7'h37, 7'h17: begin
				r.data = (opc == 7'h17) ? pc + imm_u : imm_u;
				r.rd_wena = 1'b1;
				r.be = '0;
			end
			7'h6f, 7'h67: begin
				r.data = pc + 64'd4;
				r.rd_wena = 1'b1;
				r.br_taken = 1'b1;
				r.target = (opc == 7'h6f) ? pc + imm_j : (a + imm_i) & ~64'd1;
				r.be = '0;
			end
			7'h63: begin
				op2 = shadow[inst[24:20]];
				case (f3)
					3'd0: r.br_taken = (a == op2);
					3'd1: r.br_taken = (a != op2);
					3'd4: r.br_taken = $signed(a) < $signed(op2);
					3'd5: r.br_taken = $signed(a) >= $signed(op2);
					3'd6: r.br_taken = a < op2;
					default: r.br_taken = a >= op2;
				endcase
				r.target = pc + imm_b;
				r.be = '0;
			end
			7'h03, 7'h23: begin
				// no data memory, the address is both data and target
				r.data = a + ((opc == 7'h03) ? imm_i : imm_s);
				r.target = r.data;
				r.rena = (opc == 7'h03);
				r.wena = (opc == 7'h23);
				r.rd_wena = r.rena;
			end
			default: begin
				r = '{default: '0};
				r.pc = pc;
				r.illegal = 1'b1;
			end
		endcase
		if (r.rd_wena && r.rd != 5'd0)
			shadow[r.rd] = r.data;
		return r;
	endfunction

	task automatic check_field(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic build_program();
		logic [2:0] f3;
		logic [6:0] opc;
		prog.push_back(enc_i(12'hffb, 0, 0, 1, 7'h13));
		prog.push_back(enc_i(12'd100, 1, 0, 2, 7'h13));
		prog.push_back({20'h80000, 5'd3, 7'h37});
		// addiw wraps below bit 31, so a plain 64-bit add gives another value
		prog.push_back(enc_i(12'hfff, 3, 0, 4, 7'h1b));
		prog.push_back(enc_r(7'h00, 2, 1, 0, 5, 7'h33));
		prog.push_back(enc_r(7'h20, 2, 1, 0, 6, 7'h33));
		prog.push_back(enc_r(7'h00, 2, 3, 1, 7, 7'h33));
		prog.push_back(enc_r(7'h20, 2, 3, 5, 8, 7'h3b));
		prog.push_back(enc_i(12'h403, 1, 5, 9, 7'h13));
		prog.push_back(enc_i(12'd4, 2, 1, 10, 7'h1b));
		prog.push_back(enc_r(7'h00, 2, 1, 3, 11, 7'h33));
		prog.push_back(enc_r(7'h00, 2, 1, 2, 12, 7'h33));
		prog.push_back(enc_i(12'h0f0, 1, 4, 13, 7'h13));
		prog.push_back({20'h12345, 5'd14, 7'h17});
		for (int i = 0; i < 6; i++)
			prog.push_back(enc_b(13'h0010, 2, 1, (i < 2) ? 3'(i) : 3'(i + 2)));
		prog.push_back(enc_b(13'h1ff8, 1, 1, 0));
		prog.push_back(enc_j(21'h000800, 15));
		// odd sum, so jalr has to clear bit 0
		prog.push_back(enc_i(12'd8, 2, 0, 16, 7'h67));
		prog.push_back(enc_i(12'd8, 2, 3, 17, 7'h03));
		prog.push_back(enc_i(12'hfff, 1, 4, 18, 7'h03));
		prog.push_back(enc_i(12'd2, 2, 1, 19, 7'h03));
		prog.push_back(enc_s(12'd16, 5, 2, 3));
		prog.push_back(enc_s(12'h801, 5, 2, 0));
		prog.push_back(enc_s(12'd4, 5, 2, 2));
		prog.push_back(32'h0000007f);
		prog.push_back(32'h00000073);
		// random integer ops on a few registers so results chain
		for (int i = 0; i < 40; i++) begin
			opc = (rand_bits(2) == 0) ? 7'h3b : (rand_bits(1) ? 7'h33 : 7'h13);
			f3 = 3'(rand_bits(3));
			if (opc == 7'h3b && f3 != 3'd1 && f3 != 3'd5)
				f3 = 3'd0;
			prog.push_back(enc_r({1'b0, rand_bits(1) ? 6'h20 : 6'h00}, 5'(rand_bits(3)),
				5'(rand_bits(3)), f3, 5'(rand_bits(3)), opc));
		end
	endtask

	task automatic send_all();
		int waits;
		for (int i = 0; i < prog.size(); i++) begin
			waits = 0;
			while (credits == 0) begin
				in_valid = 1'b0;
				if (waits == 200) begin
					$display("timeout waiting for an input credit");
					failures++;
					return;
				end
				waits++;
				@(posedge clk);
				#1;
			end
			in_valid = 1'b1;
			in_inst = prog[i];
			in_pc = 64'h1000 + 64'(4 * i);
			expq.push_back(model(prog[i], in_pc));
			credits--;
			sent++;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			if (in_credit)
				credits++;
			if (res_valid) begin
				received++;
				pend++;
				if (expq.size() == 0) begin
					$display("result arrived with no instruction outstanding");
					failures++;
				end else begin
					head = expq.pop_front();
					check_field("res_pc", res_pc, head.pc);
					check_field("res_data", res_data, head.data);
					check_field("res_rd", 64'(res_rd), 64'(head.rd));
					check_field("res_rd_wena", 64'(res_rd_wena), 64'(head.rd_wena));
					check_field("res_br_taken", 64'(res_br_taken), 64'(head.br_taken));
					check_field("res_target", res_target, head.target);
					check_field("res_mem_rena", 64'(res_mem_rena), 64'(head.rena));
					check_field("res_mem_wena", 64'(res_mem_wena), 64'(head.wena));
					check_field("res_byte_enable", 64'(res_byte_enable), 64'(head.be));
					check_field("res_illegal", 64'(res_illegal), 64'(head.illegal));
				end
			end
		end
	end

	// output credits come back at random, about one cycle in four
	always @(posedge clk) begin
		#1;
		if (!rst && pend > 0 && lfsr_bit() && lfsr_bit()) begin
			res_credit = 1'b1;
			pend--;
		end else begin
			res_credit = 1'b0;
		end
	end

	initial begin
		int waits;
		rst = 1'b1;
		in_valid = 1'b0;
		in_inst = '0;
		in_pc = '0;
		res_credit = 1'b0;
		lfsr = 32'h89e;
		credits = `IN_CREDITS;
		foreach (shadow[i])
			shadow[i] = '0;
		build_program();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		send_all();
		waits = 0;
		while (expq.size() != 0 && waits < 2000) begin
			@(posedge clk);
			waits++;
		end
		if (expq.size() != 0) begin
			$display("timeout waiting for %0d outstanding results", expq.size());
			failures++;
		end
		repeat (10) @(posedge clk);
		if (received != sent) begin
			$display("result count %0d differs from instructions sent %0d", received, sent);
			failures++;
		end
		$display("sent %0d, received %0d, mismatches %0d, other failures %0d",
			sent, received, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: rv64_chk.sv
// credit protocol and reset assertions for the RV64I slice, bound to the top level
`include "rv64_macros.svh"

module rv64_chk (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_credit,
	input logic res_valid,
	input logic res_credit
);
	int unsigned accepted;
	int unsigned returned;
	int unsigned results;
	int unsigned res_credits;
	logic        seen_in;

	always_ff @(posedge clk) begin
		if (rst) begin
			accepted <= 0;
			returned <= 0;
			results <= 0;
			res_credits <= 0;
			seen_in <= 1'b0;
		end else begin
			accepted <= accepted + (in_valid ? 1 : 0);
			returned <= returned + (in_credit ? 1 : 0);
			results <= results + (res_valid ? 1 : 0);
			res_credits <= res_credits + (res_credit ? 1 : 0);
			if (in_valid)
				seen_in <= 1'b1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) rst |=> !in_credit && !res_valid)
		else $error("in_credit or res_valid high right after reset");

	// nothing moves before the first instruction
	a_idle_before_input: assert property (@(posedge clk) disable iff (rst)
		!seen_in |-> !in_credit && !res_valid)
		else $error("activity on credit or result port before any input");

	a_in_credit_bound: assert property (@(posedge clk) disable iff (rst)
		returned <= accepted)
		else $error("more input credits returned than instructions accepted");

	// producer must hold a credit for every word it sends
	a_in_no_overrun: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> (accepted - returned) < `IN_CREDITS)
		else $error("input queue overrun");

	a_out_credit_bound: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> results < `OUT_CREDITS + res_credits)
		else $error("result emitted without an output credit");

endmodule

bind rv64_slice_top rv64_chk u_chk (
	.clk        (clk),
	.rst        (rst),
	.in_valid   (in_valid),
	.in_credit  (in_credit),
	.res_valid  (res_valid),
	.res_credit (res_credit)
);

// File: rv64_slice_top.sv
// RV64I integer slice, queue and decode feeding execute with credit ports on both sides
`include "rv64_macros.svh"

module rv64_slice_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [`INST_W-1:0]  in_inst,
	input  logic [`XLEN-1:0]    in_pc,
	output logic                in_credit,
	input  logic                res_credit,
	output logic                res_valid,
	output logic [`XLEN-1:0]    res_pc,
	output logic [`XLEN-1:0]    res_data,
	output logic [`REG_AW-1:0]  res_rd,
	output logic                res_rd_wena,
	output logic                res_br_taken,
	output logic [`XLEN-1:0]    res_target,
	output logic                res_mem_rena,
	output logic                res_mem_wena,
	output logic [7:0]          res_byte_enable,
	output logic                res_illegal
);
	logic                head_valid;
	logic [`INST_W-1:0]  head_inst;
	logic [`XLEN-1:0]    head_pc;
	logic                pop;
	logic [`REG_AW-1:0]  rs1_addr;
	logic [`REG_AW-1:0]  rs2_addr;
	logic [`XLEN-1:0]    rs1_data;
	logic [`XLEN-1:0]    rs2_data;
	logic                wb_wena;
	logic [`REG_AW-1:0]  wb_waddr;
	logic [`XLEN-1:0]    wb_wdata;

	id_ex_if id_ex ();

	inst_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_inst    (in_inst),
		.in_pc      (in_pc),
		.in_credit  (in_credit),
		.head_valid (head_valid),
		.head_inst  (head_inst),
		.head_pc    (head_pc),
		.pop        (pop)
	);

	id_stage u_id (
		.head_valid (head_valid),
		.inst       (head_inst),
		.pc         (head_pc),
		.pop        (pop),
		.ex         (id_ex.producer),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data)
	);

	regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_wena  (wb_wena),
		.wb_waddr (wb_waddr),
		.wb_wdata (wb_wdata)
	);

	exe_stage u_exe (
		.clk             (clk),
		.rst             (rst),
		.ex              (id_ex.consumer),
		.res_credit      (res_credit),
		.res_valid       (res_valid),
		.res_pc          (res_pc),
		.res_data        (res_data),
		.res_rd          (res_rd),
		.res_rd_wena     (res_rd_wena),
		.res_br_taken    (res_br_taken),
		.res_target      (res_target),
		.res_mem_rena    (res_mem_rena),
		.res_mem_wena    (res_mem_wena),
		.res_byte_enable (res_byte_enable),
		.res_illegal     (res_illegal),
		.wb_wena         (wb_wena),
		.wb_waddr        (wb_waddr),
		.wb_wdata        (wb_wdata)
	);

endmodule

// File: exe_stage.sv
// execute stage, registers the decoded record, runs the ALU and emits results on credit
`include "rv64_macros.svh"

module exe_stage import rv64_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	id_ex_if.consumer           ex,
	input  logic                res_credit,
	output logic                res_valid,
	output logic [`XLEN-1:0]    res_pc,
	output logic [`XLEN-1:0]    res_data,
	output logic [`REG_AW-1:0]  res_rd,
	output logic                res_rd_wena,
	output logic                res_br_taken,
	output logic [`XLEN-1:0]    res_target,
	output logic                res_mem_rena,
	output logic                res_mem_wena,
	output logic [7:0]          res_byte_enable,
	output logic                res_illegal,
	output logic                wb_wena,
	output logic [`REG_AW-1:0]  wb_waddr,
	output logic [`XLEN-1:0]    wb_wdata
);
	localparam int CW = $clog2(`OUT_CREDITS + 1);

	logic              ex_valid;
	dec_ctrl_t         ctrl_q;
	logic [`XLEN-1:0]  pc_q;
	logic [`XLEN-1:0]  rs1_q;
	logic [`XLEN-1:0]  rs2_q;
	logic [CW-1:0]     credits;
	logic              fire;
	logic              take;
	logic [`XLEN-1:0]  op_a;
	logic [`XLEN-1:0]  op_b;
	logic [`XLEN-1:0]  alu_result;
	logic [`XLEN-1:0]  pc_target;
	logic [`XLEN-1:0]  reg_target;
	logic              br_taken;

	// record leaves when a credit is there, a new one may enter the same cycle
	assign fire = ex_valid && (credits != '0);
	assign ex.stall = ex_valid && (credits == '0);
	assign take = ex.valid && !ex.stall;

	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else if (take)
			ex_valid <= 1'b1;
		else if (fire)
			ex_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			ctrl_q <= ex.ctrl;
			pc_q <= ex.pc;
			rs1_q <= ex.rs1_data;
			rs2_q <= ex.rs2_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CW'(`OUT_CREDITS);
		end else begin
			case ({fire, res_credit})
				2'b10: credits <= credits - CW'(1);
				2'b01: credits <= credits + CW'(1);
				default: credits <= credits;
			endcase
		end
	end

	always_comb begin
		op_a = (ctrl_q.op1_src == OP1_PC) ? pc_q : rs1_q;
		case (ctrl_q.op2_src)
			OP2_IMM: op_b = ctrl_q.imm;
			OP2_FOUR: op_b = `XLEN'(4);
			default: op_b = rs2_q;
		endcase
	end

	alu u_alu (
		.alu_op   (ctrl_q.alu_op),
		.op_a     (op_a),
		.op_b     (op_b),
		.result   (alu_result),
		.br_taken (br_taken)
	);

	assign pc_target = pc_q + ctrl_q.imm;
	assign reg_target = rs1_q + ctrl_q.imm;

	// jalr clears bit 0, loads and stores report their address here
	always_comb begin
		if (ctrl_q.jalr)
			res_target = {reg_target[`XLEN-1:1], 1'b0};
		else if (ctrl_q.mem_rena || ctrl_q.mem_wena)
			res_target = reg_target;
		else if (ctrl_q.branch || ctrl_q.jump)
			res_target = pc_target;
		else
			res_target = '0;
	end

	assign res_valid = fire;
	assign res_pc = pc_q;
	assign res_data = alu_result;
	assign res_rd = ctrl_q.rd;
	assign res_rd_wena = ctrl_q.rd_wena;
	assign res_br_taken = (ctrl_q.branch && br_taken) || ctrl_q.jump;
	assign res_mem_rena = ctrl_q.mem_rena;
	assign res_mem_wena = ctrl_q.mem_wena;
	assign res_byte_enable = ctrl_q.byte_enable;
	assign res_illegal = ctrl_q.illegal;

	// writeback lands in the cycle the result leaves
	assign wb_wena = fire && ctrl_q.rd_wena;
	assign wb_waddr = ctrl_q.rd;
	assign wb_wdata = alu_result;

endmodule

// File: alu.sv
// 64-bit integer ALU with W forms and branch compare
`include "rv64_macros.svh"

module alu import rv64_pkg::*; (
	input  alu_op_e             alu_op,
	input  logic [`XLEN-1:0]    op_a,
	input  logic [`XLEN-1:0]    op_b,
	output logic [`XLEN-1:0]    result,
	output logic                br_taken
);
	logic [5:0]   shamt;
	logic [4:0]   shamt_w;
	logic [31:0]  a_w;
	logic [31:0]  b_w;
	logic         lt_s;
	logic         lt_u;
	logic         eq;

	function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
		return {{(`XLEN - 32){v[31]}}, v};
	endfunction

	assign shamt = op_b[5:0];
	assign shamt_w = op_b[4:0];
	assign a_w = op_a[31:0];
	assign b_w = op_b[31:0];

	// one comparator set shared by slt and the branches
	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;
	assign eq = (op_a == op_b);

	always_comb begin
		result = '0;
		br_taken = 1'b0;
		case (alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_SLT: result = {{(`XLEN - 1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(`XLEN - 1){1'b0}}, lt_u};
			ALU_XOR: result = op_a ^ op_b;
			ALU_OR: result = op_a | op_b;
			ALU_AND: result = op_a & op_b;
			ALU_SLL: result = op_a << shamt;
			ALU_SRL: result = op_a >> shamt;
			ALU_SRA: result = $signed(op_a) >>> shamt;
			// W forms work on the low word and sign-extend it
			ALU_ADDW: result = sext32(a_w + b_w);
			ALU_SUBW: result = sext32(a_w - b_w);
			ALU_SLLW: result = sext32(a_w << shamt_w);
			ALU_SRLW: result = sext32(a_w >> shamt_w);
			ALU_SRAW: result = sext32($signed(a_w) >>> shamt_w);
			ALU_LUI: result = op_b;
			// branches only raise the flag, result stays zero
			ALU_BEQ: br_taken = eq;
			ALU_BNE: br_taken = !eq;
			ALU_BLT: br_taken = lt_s;
			ALU_BGE: br_taken = !lt_s;
			ALU_BLTU: br_taken = lt_u;
			ALU_BGEU: br_taken = !lt_u;
			default: result = '0;
		endcase
	end

endmodule

// File: regfile.sv
// 32 x 64 integer register file, x0 reads zero, writes bypass to reads
`include "rv64_macros.svh"

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic [`REG_AW-1:0]  rs1_addr,
	input  logic [`REG_AW-1:0]  rs2_addr,
	output logic [`XLEN-1:0]    rs1_data,
	output logic [`XLEN-1:0]    rs2_data,
	input  logic                wb_wena,
	input  logic [`REG_AW-1:0]  wb_waddr,
	input  logic [`XLEN-1:0]    wb_wdata
);
	logic [`XLEN-1:0] regs [`REG_NUM];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_NUM; i++)
				regs[i] <= '0;
		end else if (wb_wena && wb_waddr != '0) begin
			regs[wb_waddr] <= wb_wdata;
		end
	end

	// same-cycle write wins, except for x0
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb_wena && wb_waddr == addr)
			return wb_wdata;
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1_addr);
		rs2_data = read_port(rs2_addr);
	end

endmodule

// File: id_stage.sv
// RV64I decoder, turns the queue head into a decode/execute record
`include "rv64_macros.svh"

module id_stage import rv64_pkg::*; (
	input  logic                 head_valid,
	input  logic [`INST_W-1:0]   inst,
	input  logic [`XLEN-1:0]     pc,
	output logic                 pop,
	id_ex_if.producer            ex,
	output logic [`REG_AW-1:0]   rs1_addr,
	output logic [`REG_AW-1:0]   rs2_addr,
	input  logic [`XLEN-1:0]     rs1_data,
	input  logic [`XLEN-1:0]     rs2_data
);
	opcode_e           opcode;
	logic [2:0]        f3;
	logic              b30;
	logic [`XLEN-1:0]  imm_i;
	logic [`XLEN-1:0]  imm_s;
	logic [`XLEN-1:0]  imm_b;
	logic [`XLEN-1:0]  imm_u;
	logic [`XLEN-1:0]  imm_j;
	logic [7:0]        be;
	logic              illegal;
	dec_ctrl_t         c;

	// integer ops, sub_ok only for register forms where bit 30 is not immediate
	function automatic alu_op_e alu_sel(input logic [2:0] fn, input logic alt,
			input logic word, input logic sub_ok);
		alu_op_e op;
		op = ALU_ZERO;
		case (fn)
			F3_ADD: begin
				if (sub_ok && alt)
					op = word ? ALU_SUBW : ALU_SUB;
				else
					op = word ? ALU_ADDW : ALU_ADD;
			end
			F3_SLL: op = word ? ALU_SLLW : ALU_SLL;
			F3_SR: begin
				if (alt)
					op = word ? ALU_SRAW : ALU_SRA;
				else
					op = word ? ALU_SRLW : ALU_SRL;
			end
			F3_SLT: op = word ? ALU_ZERO : ALU_SLT;
			F3_SLTU: op = word ? ALU_ZERO : ALU_SLTU;
			F3_XOR: op = word ? ALU_ZERO : ALU_XOR;
			F3_OR: op = word ? ALU_ZERO : ALU_OR;
			F3_AND: op = word ? ALU_ZERO : ALU_AND;
			default: op = ALU_ZERO;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign f3 = inst[14:12];
	assign b30 = inst[30];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// access size from the low funct3 bits, same for loads and stores
	always_comb begin
		case (f3[1:0])
			2'b00: be = 8'h01;
			2'b01: be = 8'h03;
			2'b10: be = 8'h0f;
			default: be = 8'hff;
		endcase
	end

	always_comb begin
		c = '0;
		illegal = 1'b0;
		c.rd = inst[11:7];
		c.imm = imm_i;
		case (opcode)
			OPC_OP_IMM, OPC_OP_IMM32: begin
				c.alu_op = alu_sel(f3, b30, opcode == OPC_OP_IMM32, 1'b0);
				c.op2_src = OP2_IMM;
				c.rd_wena = 1'b1;
			end
			OPC_OP, OPC_OP32: begin
				c.alu_op = alu_sel(f3, b30, opcode == OPC_OP32, 1'b1);
				c.rd_wena = 1'b1;
			end
			OPC_LUI: begin
				c.alu_op = ALU_LUI;
				c.op2_src = OP2_IMM;
				c.imm = imm_u;
				c.rd_wena = 1'b1;
			end
			OPC_AUIPC: begin
				c.alu_op = ALU_ADD;
				c.op1_src = OP1_PC;
				c.op2_src = OP2_IMM;
				c.imm = imm_u;
				c.rd_wena = 1'b1;
			end
			// link value pc+4 from the alu, target is built in execute
			OPC_JAL, OPC_JALR: begin
				c.alu_op = ALU_ADD;
				c.op1_src = OP1_PC;
				c.op2_src = OP2_FOUR;
				c.imm = (opcode == OPC_JAL) ? imm_j : imm_i;
				c.rd_wena = 1'b1;
				c.jump = 1'b1;
				c.jalr = (opcode == OPC_JALR);
			end
			OPC_BRANCH: begin
				c.imm = imm_b;
				c.branch = 1'b1;
				case (f3)
					F3_BEQ: c.alu_op = ALU_BEQ;
					F3_BNE: c.alu_op = ALU_BNE;
					F3_BLT: c.alu_op = ALU_BLT;
					F3_BGE: c.alu_op = ALU_BGE;
					F3_BLTU: c.alu_op = ALU_BLTU;
					F3_BGEU: c.alu_op = ALU_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				c.alu_op = ALU_ADD;
				c.op2_src = OP2_IMM;
				c.rd_wena = 1'b1;
				c.mem_rena = 1'b1;
				c.mem_unsigned = f3[2];
				c.byte_enable = be;
				// no unsigned doubleword
				illegal = (f3 == 3'b111);
			end
			OPC_STORE: begin
				c.alu_op = ALU_ADD;
				c.op2_src = OP2_IMM;
				c.imm = imm_s;
				c.mem_wena = 1'b1;
				c.byte_enable = be;
				illegal = f3[2];
			end
			// no csr file in this slice
			OPC_SYSTEM: illegal = 1'b1;
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			c = '0;
			c.illegal = 1'b1;
		end
	end

	assign ex.valid = head_valid;
	assign ex.ctrl = c;
	assign ex.pc = pc;
	assign ex.rs1_data = rs1_data;
	assign ex.rs2_data = rs2_data;
	assign pop = head_valid && !ex.stall;

endmodule

// File: inst_queue.sv
// instruction queue, one entry per input credit, returns a credit per pop
`include "rv64_macros.svh"

module inst_queue (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  logic [`INST_W-1:0]   in_inst,
	input  logic [`XLEN-1:0]     in_pc,
	output logic                 in_credit,
	output logic                 head_valid,
	output logic [`INST_W-1:0]   head_inst,
	output logic [`XLEN-1:0]     head_pc,
	input  logic                 pop
);
	localparam int DEPTH = `IN_CREDITS;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [`INST_W-1:0] inst_mem [DEPTH];
	logic [`XLEN-1:0]   pc_mem [DEPTH];
	logic [PW-1:0]      wr_ptr;
	logic [PW-1:0]      rd_ptr;
	logic [CW-1:0]      count;

	// wrap also for depths that are not a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + PW'(1);
	endfunction

	always_ff @(posedge clk) begin
		if (in_valid) begin
			inst_mem[wr_ptr] <= in_inst;
			pc_mem[wr_ptr] <= in_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({in_valid, pop})
				2'b10: count <= count + CW'(1);
				2'b01: count <= count - CW'(1);
				default: count <= count;
			endcase
			// one credit pulse per popped entry
			in_credit <= pop;
		end
	end

	assign head_valid = (count != '0);
	assign head_inst = inst_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];

endmodule

// File: rv64_pkg.sv
// shared RV64I slice types and the decode-to-execute interface
`include "rv64_macros.svh"

package rv64_pkg;

	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP_IMM32 = 7'b0011011,
		OPC_OP       = 7'b0110011,
		OPC_OP32     = 7'b0111011,
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_BRANCH   = 7'b1100011,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// funct3 of OP / OP_IMM and their W forms
	typedef enum logic [2:0] {
		F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_OR, F3_AND
	} f3_alu_e;

	// funct3 of BRANCH, 010 and 011 are reserved
	typedef enum logic [2:0] {
		F3_BEQ = 3'b000, F3_BNE = 3'b001, F3_BLT = 3'b100,
		F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111
	} f3_br_e;

	typedef enum logic [4:0] {
		ALU_ZERO,
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
		ALU_LUI,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic {OP1_REG, OP1_PC} op1_src_e;

	typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_FOUR} op2_src_e;

	typedef struct packed {
		alu_op_e             alu_op;
		op1_src_e            op1_src;
		op2_src_e            op2_src;
		logic [`XLEN-1:0]    imm;
		logic [`REG_AW-1:0]  rd;
		logic                rd_wena;
		logic                branch;
		// jump covers jal and jalr, jalr picks the register target
		logic                jump;
		logic                jalr;
		logic                mem_rena;
		logic                mem_wena;
		logic                mem_unsigned;
		logic [7:0]          byte_enable;
		logic                illegal;
	} dec_ctrl_t;

endpackage

interface id_ex_if import rv64_pkg::*; ();
	logic              valid;
	dec_ctrl_t         ctrl;
	logic [`XLEN-1:0]  pc;
	logic [`XLEN-1:0]  rs1_data;
	logic [`XLEN-1:0]  rs2_data;
	// execute side cannot take a record this cycle
	logic              stall;

	modport producer (output valid, ctrl, pc, rs1_data, rs2_data, input stall);
	modport consumer (input valid, ctrl, pc, rs1_data, rs2_data, output stall);
endinterface

// File: rv64_macros.svh
// rv64 slice widths, register count and credit depths
`ifndef RV64_MACROS_SVH
`define RV64_MACROS_SVH

// data path width
`define XLEN 64

// register file geometry
`define REG_AW 5
`define REG_NUM 32

// instruction word width
`define INST_W 32

// queue depth, also the credits the producer starts with
`define IN_CREDITS 4

// credits the result consumer hands out after reset
`define OUT_CREDITS 2

`endif
